// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_muldiv -f tb.f -o sim_muldiv

./obj_dir/sim_muldiv > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== source/hilo_regs.sv ====
`default_nettype none

module hilo_regs import muldiv_pkg::*; (
    input  logic           clk,
    input  logic           arst_n,
    input  muldiv_commit_t commit,
    output dword_t         hilo
);

    logic write_en;

    // excepting results never reach architectural state
    assign write_en = commit.valid && !commit.exception;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hilo <= '0;
        end else if (write_en) begin
            hilo <= {commit.hi, commit.lo};
        end
    end

endmodule

`default_nettype wire

// ==== source/muldiv_pkg.sv ====
`default_nettype none

package muldiv_pkg;

    // machine word and hi/lo pair with hi in the upper half
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // reorder buffer index
    typedef logic [4:0] rob_addr_t;

    // divider runs one iteration per quotient bit
    localparam int DIV_CYCLES = $bits(word_t);

    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_MULT  = 3'd1,
        OP_MULTU = 3'd2,
        OP_DIV   = 3'd3,
        OP_DIVU  = 3'd4
    } muldiv_op_t;

    // instruction as handed over by the issue stage
    typedef struct packed {
        logic       valid;
        muldiv_op_t op;
        rob_addr_t  dst;
        logic       exception;
    } issued_instr_t;

    // result record towards the reorder buffer
    typedef struct packed {
        logic      valid;
        word_t     hi;
        word_t     lo;
        rob_addr_t rob_addr;
        logic      exception;
    } muldiv_commit_t;

    function automatic logic is_mul_op(muldiv_op_t op);
        return (op == OP_MULT) || (op == OP_MULTU);
    endfunction

    function automatic logic is_div_op(muldiv_op_t op);
        return (op == OP_DIV) || (op == OP_DIVU);
    endfunction

endpackage

`default_nettype wire

// ==== source/muldiv_top.sv ====
`default_nettype none

module muldiv_top import muldiv_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           flush,
    input  word_t          a,
    input  word_t          b,
    input  issued_instr_t  issue,
    output logic           ok,
    output muldiv_commit_t commit,
    output dword_t         hilo
);

    // execution unit
    muldiv_unit #(
        .MUL_STAGES(MUL_STAGES)
    ) u_unit (
        .clk,
        .arst_n,
        .flush,
        .a,
        .b,
        .issue,
        .ok,
        .commit
    );

    // architectural hi/lo written from the commit record
    hilo_regs u_hilo (
        .clk,
        .arst_n,
        .commit,
        .hilo
    );

endmodule

`default_nettype wire

// ==== source/muldiv_unit.sv ====
`default_nettype none

module muldiv_unit import muldiv_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           flush,
    input  word_t          a,
    input  word_t          b,
    input  issued_instr_t  issue,
    output logic           ok,
    output muldiv_commit_t commit
);

    typedef enum logic {
        S_IDLE,
        S_BUSY
    } state_t;

    state_t state;
    issued_instr_t instr_q;
    word_t a_q;
    word_t b_q;
    logic accept;

    logic mul_start;
    logic div_start;
    logic [MUL_STAGES-1:0] mul_live;
    dword_t mul_product;
    logic mul_done;
    word_t div_quotient;
    word_t div_remainder;
    logic div_done;

    logic instr_is_mul;
    logic eng_done;
    dword_t eng_result;

    logic commit_valid;
    dword_t commit_hilo;
    rob_addr_t commit_rob;
    logic commit_exc;

    // stays low through the commit cycle
    assign ok = (state == S_IDLE) && !commit_valid;

    assign accept = ok && issue.valid && !flush
                    && (is_mul_op(issue.op) || is_div_op(issue.op));

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= a;
            b_q <= b;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= S_IDLE;
            instr_q      <= '0;
            mul_start    <= 1'b0;
            div_start    <= 1'b0;
            mul_live     <= '0;
            commit_valid <= 1'b0;
        end else if (flush) begin
            state        <= S_IDLE;
            instr_q      <= '0;
            mul_start    <= 1'b0;
            div_start    <= 1'b0;
            mul_live     <= '0;
            commit_valid <= 1'b0;
        end else begin
            mul_start    <= accept && is_mul_op(issue.op);
            div_start    <= accept && is_div_op(issue.op);
            // tracks which multiplier slots still belong to a live op
            mul_live     <= (mul_live << 1) | MUL_STAGES'(mul_start);
            commit_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        instr_q <= issue;
                        state   <= S_BUSY;
                    end
                end
                S_BUSY: begin
                    if (eng_done) begin
                        commit_valid <= 1'b1;
                        state        <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign instr_is_mul = is_mul_op(instr_q.op);

    pipelined_multiplier #(
        .MUL_STAGES(MUL_STAGES)
    ) u_mul (
        .clk,
        .arst_n,
        .start     (mul_start),
        .is_signed (instr_q.op == OP_MULT),
        .a         (a_q),
        .b         (b_q),
        .product   (mul_product),
        .done      (mul_done)
    );

    radix2_divider u_div (
        .clk,
        .arst_n,
        .flush,
        .start     (div_start),
        .is_signed (instr_q.op == OP_DIV),
        .a         (a_q),
        .b         (b_q),
        .quotient  (div_quotient),
        .remainder (div_remainder),
        .done      (div_done)
    );

    // a multiply abandoned by flush may still drain out of the pipe
    assign eng_done   = instr_is_mul ? (mul_done && mul_live[MUL_STAGES-1]) : div_done;
    // divides put the remainder in hi and the quotient in lo
    assign eng_result = instr_is_mul ? mul_product : {div_remainder, div_quotient};

    always_ff @(posedge clk) begin
        if (state == S_BUSY && eng_done) begin
            commit_hilo <= eng_result;
            commit_rob  <= instr_q.dst;
            commit_exc  <= instr_q.exception;
        end
    end

    assign commit.valid     = commit_valid;
    assign commit.hi        = commit_hilo[63:32];
    assign commit.lo        = commit_hilo[31:0];
    assign commit.rob_addr  = commit_rob;
    assign commit.exception = commit_exc;

endmodule

`default_nettype wire

// ==== source/pipelined_multiplier.sv ====
`default_nettype none

module pipelined_multiplier import muldiv_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   start,
    input  logic   is_signed,
    input  word_t  a,
    input  word_t  b,
    output dword_t product,
    output logic   done
);

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [63:0] full_prod;

    dword_t prod_q [MUL_STAGES];
    logic [MUL_STAGES-1:0] vld_q;

    // extra top bit lets multu share the signed multiply
    assign a_ext = {is_signed & a[31], a};
    assign b_ext = {is_signed & b[31], b};

    // only the low 64 bits of the 66 bit product are meaningful
    assign full_prod = a_ext * b_ext;

    // product travels in step with the valid pipe
    always_ff @(posedge clk) begin
        prod_q[0] <= full_prod;
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i - 1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start;
            for (int i = 1; i < MUL_STAGES; i++) begin
                vld_q[i] <= vld_q[i - 1];
            end
        end
    end

    assign product = prod_q[MUL_STAGES-1];
    assign done    = vld_q[MUL_STAGES-1];

endmodule

`default_nettype wire

// ==== source/radix2_divider.sv ====
`default_nettype none

module radix2_divider import muldiv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  flush,
    input  logic  start,
    input  logic  is_signed,
    input  word_t a,
    input  word_t b,
    output word_t quotient,
    output word_t remainder,
    output logic  done
);

    localparam int CNT_W = $clog2(DIV_CYCLES + 1);

    logic [CNT_W-1:0] cnt;
    word_t a_mag;
    word_t b_mag;
    word_t divisor;
    word_t rem;
    word_t quo;
    logic neg_q;
    logic neg_r;
    logic [32:0] trial;

    // magnitudes of the operands
    assign a_mag = (is_signed && a[31]) ? -a : a;
    assign b_mag = (is_signed && b[31]) ? -b : b;

    // shift in the next dividend bit and try the subtract
    assign trial = {rem, quo[31]} - {1'b0, divisor};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (flush) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                cnt <= CNT_W'(DIV_CYCLES);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                // last iteration
                done <= (cnt == CNT_W'(1));
            end
        end
    end

    // quo doubles as the dividend shift register
    always_ff @(posedge clk) begin
        if (start) begin
            divisor <= b_mag;
            rem     <= '0;
            quo     <= a_mag;
            // divide by zero keeps the all ones quotient
            neg_q   <= is_signed && (a[31] ^ b[31]) && (b != '0);
            neg_r   <= is_signed && a[31];
        end else if (cnt != '0) begin
            if (!trial[32]) begin
                rem <= trial[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= {rem[30:0], quo[31]};
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    // sign fix-up where the remainder follows the dividend
    assign quotient  = neg_q ? -quo : quo;
    assign remainder = neg_r ? -rem : rem;

endmodule

`default_nettype wire

// ==== tb.f ====
source/muldiv_pkg.sv
source/pipelined_multiplier.sv
source/radix2_divider.sv
source/muldiv_unit.sv
source/hilo_regs.sv
source/muldiv_top.sv
testbench/muldiv_checker.sv
testbench/tb_muldiv.sv

// ==== testbench/muldiv_checker.sv ====
`default_nettype none

module muldiv_checker import muldiv_pkg::*; (
    input logic           clk,
    input logic           arst_n,
    input logic           flush,
    input logic           ok,
    input muldiv_commit_t commit
);

    timeunit 1ns;
    timeprecision 100ps;

    // a commit lasts exactly one cycle
    property commit_is_pulse;
        @(posedge clk) disable iff (!arst_n)
            commit.valid |=> !commit.valid;
    endproperty

    // the unit never looks ready while it is committing
    property ok_low_on_commit;
        @(posedge clk) disable iff (!arst_n)
            commit.valid |-> !ok;
    endproperty

    // flush kills whatever was about to commit
    property no_commit_after_flush;
        @(posedge clk) disable iff (!arst_n)
            flush |=> !commit.valid;
    endproperty

    assert property (commit_is_pulse)
        else $error("commit.valid stayed high for more than one cycle");
    assert property (ok_low_on_commit)
        else $error("ok was high in a commit cycle");
    assert property (no_commit_after_flush)
        else $error("commit appeared in the cycle after a flush");

endmodule

bind muldiv_unit muldiv_checker u_checker (
    .clk,
    .arst_n,
    .flush,
    .ok,
    .commit
);

`default_nettype wire

// ==== testbench/tb_muldiv.sv ====
`default_nettype none

module tb_muldiv import muldiv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // same as the top level default
    localparam int MUL_STAGES = 3;
    // roughly the number of operations issued over the whole run
    localparam int NUM_OPS = 112;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (DIV_CYCLES + 2) + 512;

    logic clk;
    logic arst_n;
    logic flush;
    word_t a;
    word_t b;
    issued_instr_t issue;
    logic ok;
    muldiv_commit_t commit;
    dword_t hilo;

    integer seed;
    int errors = 0;
    int checks = 0;
    int commits = 0;
    int cycles = 0;

    muldiv_top dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (flush),
        .a      (a),
        .b      (b),
        .issue  (issue),
        .ok     (ok),
        .commit (commit),
        .hilo   (hilo)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // commits are counted on the edge that ends the commit cycle
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (commit.valid) begin
            commits <= commits + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic compare_commit(string name, muldiv_commit_t exp, muldiv_commit_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h_%h rob %0d exc %b, actual %h_%h rob %0d exc %b",
                     name, exp.hi, exp.lo, exp.rob_addr, exp.exception,
                     act.hi, act.lo, act.rob_addr, act.exception);
        end
    endtask

    task automatic compare_hilo(string name, dword_t exp, dword_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: hilo expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_ok(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: ok expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic compare_count(string name, int exp, int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[ERROR] %s: commit count expected %0d actual %0d", name, exp, act);
        end
    endtask

    // hi holds the remainder and lo the quotient for divides
    function automatic dword_t ref_result(muldiv_op_t op, word_t x, word_t y);
        dword_t res;
        word_t quo;
        word_t rem;
        if (op == OP_MULT) begin
            res = {{32{x[31]}}, x} * {{32{y[31]}}, y};
        end else if (op == OP_MULTU) begin
            res = {32'b0, x} * {32'b0, y};
        end else begin
            if (y == '0) begin
                quo = '1;
                rem = x;
            end else if (op == OP_DIV && x == 32'h8000_0000 && y == 32'hffff_ffff) begin
                quo = x;
                rem = '0;
            end else if (op == OP_DIV) begin
                quo = $signed(x) / $signed(y);
                rem = $signed(x) % $signed(y);
            end else begin
                quo = x / y;
                rem = x % y;
            end
            res = {rem, quo};
        end
        return res;
    endfunction

    function automatic int latency_of(muldiv_op_t op);
        return (op == OP_MULT || op == OP_MULTU) ? MUL_STAGES + 1 : DIV_CYCLES + 2;
    endfunction

    task automatic present(muldiv_op_t op, word_t x, word_t y, rob_addr_t dst, logic exc);
        issue <= '{1'b1, op, dst, exc};
        a <= x;
        b <= y;
    endtask

    // returns on the acceptance edge
    task automatic wait_accept();
        @(negedge clk);
        while (!ok) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic wait_commit(string name, int exp_lat, output muldiv_commit_t got,
                               output logic seen);
        int lat;
        lat = 0;
        seen = 1'b0;
        while (!seen && lat <= DIV_CYCLES + 4) begin
            @(negedge clk);
            if (commit.valid) begin
                seen = 1'b1;
                got = commit;
            end else begin
                lat++;
            end
        end
        if (!seen) begin
            errors++;
            $display("%s: no commit appeared after the operation was accepted", name);
        end else if (lat != exp_lat) begin
            errors++;
            $display("[ERROR] %s: latency expected %0d actual %0d", name, exp_lat, lat);
        end
    endtask

    task automatic check_result(string name, muldiv_op_t op, word_t x, word_t y,
                                rob_addr_t dst, logic exc, int lat, dword_t hilo_before);
        muldiv_commit_t exp;
        muldiv_commit_t got;
        dword_t res;
        logic seen;
        res = ref_result(op, x, y);
        exp = '{1'b1, res[63:32], res[31:0], dst, exc};
        wait_commit(name, lat, got, seen);
        if (seen) begin
            compare_commit(name, exp, got);
            @(negedge clk);
            compare_hilo(name, exc ? hilo_before : res, hilo);
            compare_ok(name, 1'b1, ok);
        end
    endtask

    task automatic run_op(string tag, muldiv_op_t op, word_t x, word_t y, rob_addr_t dst,
                          logic exc);
        string name;
        dword_t hilo_before;
        name = $sformatf("%s %h,%h", tag, x, y);
        hilo_before = hilo;
        @(posedge clk);
        present(op, x, y, dst, exc);
        wait_accept();
        issue <= '0;
        check_result(name, op, x, y, dst, exc, latency_of(op), hilo_before);
    endtask

    task automatic report_test(string name, int e0);
        $display("%-14s finished, %0d errors", name, errors - e0);
    endtask

    task automatic test_multiplies();
        word_t corner [4];
        word_t x;
        word_t y;
        int e0;
        corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                run_op("mult", OP_MULT, corner[i], corner[j], 5'(i * 4 + j), 1'b0);
                run_op("multu", OP_MULTU, corner[i], corner[j], 5'(i * 4 + j + 16), 1'b0);
            end
        end
        for (int k = 0; k < 20; k++) begin
            x = $random(seed);
            y = $random(seed);
            run_op("mult", OP_MULT, x, y, 5'(k), 1'b0);
            run_op("multu", OP_MULTU, x, y, 5'(k + 7), 1'b0);
        end
        report_test("multiplies", e0);
    endtask

    task automatic test_divides();
        word_t x;
        word_t y;
        int e0;
        e0 = errors;
        // shifted divisors give a spread of quotient sizes
        for (int k = 0; k < 8; k++) begin
            x = $random(seed);
            y = word_t'($random(seed)) >> (k * 3);
            run_op("div", OP_DIV, x, y, 5'(k), 1'b0);
            run_op("divu", OP_DIVU, x, y, 5'(k + 8), 1'b0);
        end
        for (int s = 0; s < 4; s++) begin
            x = s[0] ? word_t'(-1000) : 32'd1000;
            y = s[1] ? word_t'(-7) : 32'd7;
            run_op("div", OP_DIV, x, y, 5'(s + 16), 1'b0);
            run_op("divu", OP_DIVU, x, y, 5'(s + 20), 1'b0);
        end
        run_op("div by zero", OP_DIV, 32'd123, 32'd0, 5'd24, 1'b0);
        run_op("div by zero", OP_DIV, word_t'(-123), 32'd0, 5'd25, 1'b0);
        run_op("divu by zero", OP_DIVU, 32'hdead_beef, 32'd0, 5'd26, 1'b0);
        run_op("div overflow", OP_DIV, 32'h8000_0000, 32'hffff_ffff, 5'd27, 1'b0);
        run_op("divu overflow", OP_DIVU, 32'h8000_0000, 32'hffff_ffff, 5'd28, 1'b0);
        report_test("divides", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int c0;
        e0 = errors;
        c0 = commits;
        @(posedge clk);
        present(OP_DIVU, 32'd1000, 32'd7, 5'd10, 1'b0);
        wait_accept();
        // second op waits on the inputs while the divide runs
        present(OP_MULT, word_t'(-3), 32'd5, 5'd11, 1'b0);
        @(negedge clk);
        compare_ok("backpressure", 1'b0, ok);
        check_result("backpressure divu", OP_DIVU, 32'd1000, 32'd7, 5'd10, 1'b0,
                     DIV_CYCLES + 1, hilo);
        // this edge takes the held multiply now that ok is high
        @(posedge clk);
        issue <= '0;
        check_result("backpressure mult", OP_MULT, word_t'(-3), 32'd5, 5'd11, 1'b0,
                     MUL_STAGES + 1, hilo);
        compare_count("backpressure", c0 + 2, commits);
        report_test("backpressure", e0);
    endtask

    task automatic test_exception();
        int e0;
        e0 = errors;
        run_op("multu", OP_MULTU, 32'h1234_5678, 32'h9abc_def0, 5'd3, 1'b0);
        run_op("div excepting", OP_DIV, 32'd99, 32'd9, 5'd17, 1'b1);
        report_test("exception", e0);
    endtask

    task automatic test_flush();
        dword_t hilo_before;
        int e0;
        int c0;
        e0 = errors;
        hilo_before = hilo;
        c0 = commits;
        @(posedge clk);
        present(OP_DIV, 32'd100, 32'd3, 5'd20, 1'b0);
        wait_accept();
        issue <= '0;
        repeat (10) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        compare_ok("flush div", 1'b1, ok);
        repeat (DIV_CYCLES + 4) @(negedge clk);
        compare_count("flush div", c0, commits);
        compare_hilo("flush div", hilo_before, hilo);
        run_op("after flush", OP_DIVU, 32'd100, 32'd3, 5'd21, 1'b0);
        // multiply flushed while its start pulse is still in flight
        hilo_before = hilo;
        c0 = commits;
        @(posedge clk);
        present(OP_MULTU, 32'hffff_0000, 32'h0001_0001, 5'd22, 1'b0);
        wait_accept();
        issue <= '0;
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        compare_ok("flush mult", 1'b1, ok);
        compare_hilo("flush mult", hilo_before, hilo);
        run_op("after flush", OP_MULT, 32'h7fff_ffff, 32'h0000_0003, 5'd23, 1'b0);
        compare_count("flush mult", c0 + 1, commits);
        repeat (DIV_CYCLES + 4) @(negedge clk);
        compare_count("flush mult", c0 + 1, commits);
        report_test("flush", e0);
    endtask

    task automatic test_ignored_issue();
        int e0;
        int c0;
        e0 = errors;
        c0 = commits;
        @(posedge clk);
        present(OP_NONE, 32'd5, 32'd6, 5'd30, 1'b0);
        repeat (4) begin
            @(negedge clk);
            compare_ok("op none", 1'b1, ok);
        end
        @(posedge clk);
        issue <= '{1'b0, OP_MULT, 5'd31, 1'b0};
        repeat (DIV_CYCLES + 4) begin
            @(negedge clk);
            compare_ok("valid low", 1'b1, ok);
        end
        @(posedge clk);
        issue <= '0;
        @(negedge clk);
        compare_count("ignored issue", c0, commits);
        report_test("ignored issue", e0);
    endtask

    initial begin
        seed = 32'h16d003ee;
        arst_n <= 1'b0;
        flush <= 1'b0;
        a <= '0;
        b <= '0;
        issue <= '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        compare_ok("reset", 1'b1, ok);
        compare_hilo("reset", '0, hilo);
        test_multiplies();
        test_divides();
        test_backpressure();
        test_exception();
        test_flush();
        test_ignored_issue();
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
